// ==== hw/core_pkg.sv ====
package core_pkg;

typedef logic [4:0]  reg_addr_t;
typedef logic [31:0] word_t;
typedef logic [15:0] imm_t;
typedef logic [1:0]  op_t;

localparam op_t op_add  = 2'd0;
localparam op_t op_xor  = 2'd1;
localparam op_t op_addi = 2'd2;
localparam op_t op_mul  = 2'd3; // result ready in mem only.

typedef struct packed {
    op_t       op;
    reg_addr_t dest;
    reg_addr_t src1;
    reg_addr_t src2;
    imm_t      imm;
} instr_t;

typedef struct packed {
    instr_t a; // older.
    instr_t b;
    logic   b_valid;
} issue_pair_t;

// operand_2 carries the extended immediate for addi.
typedef struct packed {
    logic      valid;
    op_t       op;
    reg_addr_t dest;
    word_t     operand_1;
    word_t     operand_2;
} lane_t;

typedef struct packed {
    logic      valid;
    logic      forwardable;
    reg_addr_t dest;
    word_t     result;
} bypass_t;

typedef struct packed {
    logic      valid;
    reg_addr_t dest;
    word_t     result;
} commit_t;

endpackage

// ==== hw/forwarding_unit.sv ====
module forwarding_unit (
    input wire  core_pkg::reg_addr_t addr,
    output logic                     valid,
    output core_pkg::word_t          data,

    output core_pkg::reg_addr_t      rf_addr,
    input wire  core_pkg::word_t     rf_data,

    input wire  core_pkg::bypass_t   ex_a,
    input wire  core_pkg::bypass_t   ex_b,
    input wire  core_pkg::bypass_t   mem_a,
    input wire  core_pkg::bypass_t   mem_b,
    input wire  core_pkg::bypass_t   wb_a,
    input wire  core_pkg::bypass_t   wb_b
);

assign rf_addr = addr;

// youngest stage first, lane b before lane a.
always_comb begin
    if (addr == '0) begin
        valid = 1'b1;
        data = '0;
    end
    else if (ex_b.valid && addr == ex_b.dest) begin
        valid = ex_b.forwardable;
        data = ex_b.result;
    end
    else if (ex_a.valid && addr == ex_a.dest) begin
        valid = ex_a.forwardable;
        data = ex_a.result;
    end
    else if (mem_b.valid && addr == mem_b.dest) begin
        valid = mem_b.forwardable;
        data = mem_b.result;
    end
    else if (mem_a.valid && addr == mem_a.dest) begin
        valid = mem_a.forwardable;
        data = mem_a.result;
    end
    else if (wb_b.valid && addr == wb_b.dest) begin
        valid = wb_b.forwardable;
        data = wb_b.result;
    end
    else if (wb_a.valid && addr == wb_a.dest) begin
        valid = wb_a.forwardable;
        data = wb_a.result;
    end
    else begin
        valid = 1'b1; // nothing in flight.
        data = rf_data;
    end
end

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input wire                       clk,
    input wire                       arst_n,

    input wire  core_pkg::reg_addr_t rd_addr_0,
    input wire  core_pkg::reg_addr_t rd_addr_1,
    input wire  core_pkg::reg_addr_t rd_addr_2,
    input wire  core_pkg::reg_addr_t rd_addr_3,
    output core_pkg::word_t          rd_data_0,
    output core_pkg::word_t          rd_data_1,
    output core_pkg::word_t          rd_data_2,
    output core_pkg::word_t          rd_data_3,

    input wire  core_pkg::commit_t   commit_a,
    input wire  core_pkg::commit_t   commit_b
);

core_pkg::word_t regs [32];

assign rd_data_0 = regs[rd_addr_0];
assign rd_data_1 = regs[rd_addr_1];
assign rd_data_2 = regs[rd_addr_2];
assign rd_data_3 = regs[rd_addr_3];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end
    else begin
        if (commit_a.valid && commit_a.dest != '0) begin
            regs[commit_a.dest] <= commit_a.result;
        end
        // later write wins on equal dest.
        if (commit_b.valid && commit_b.dest != '0) begin
            regs[commit_b.dest] <= commit_b.result;
        end
    end
end

endmodule

// ==== hw/issue_stage.sv ====
module issue_stage (
    input wire                         clk,
    input wire                         arst_n,

    input wire                         issue_valid,
    input wire  core_pkg::issue_pair_t issue_pair,
    output logic                       issue_ready,

    input wire  core_pkg::bypass_t     ex_a,
    input wire  core_pkg::bypass_t     ex_b,
    input wire  core_pkg::bypass_t     mem_a,
    input wire  core_pkg::bypass_t     mem_b,
    input wire  core_pkg::bypass_t     wb_a,
    input wire  core_pkg::bypass_t     wb_b,

    output core_pkg::reg_addr_t        rf_addr_0,
    output core_pkg::reg_addr_t        rf_addr_1,
    output core_pkg::reg_addr_t        rf_addr_2,
    output core_pkg::reg_addr_t        rf_addr_3,
    input wire  core_pkg::word_t       rf_data_0,
    input wire  core_pkg::word_t       rf_data_1,
    input wire  core_pkg::word_t       rf_data_2,
    input wire  core_pkg::word_t       rf_data_3,

    output core_pkg::lane_t            lane_a,
    output core_pkg::lane_t            lane_b
);

logic                pending_valid;
core_pkg::instr_t    pending_instr;
core_pkg::instr_t    cand_a;
core_pkg::instr_t    cand_b;
logic                cand_a_valid;
logic                cand_b_valid;
core_pkg::reg_addr_t fwd_addr [4];
core_pkg::reg_addr_t fwd_rf_addr [4];
core_pkg::word_t     fwd_rf_data [4];
logic [3:0]          fwd_valid;
core_pkg::word_t     fwd_data [4];
logic                a_needs_src2;
logic                b_needs_src2;
logic                a_ops_ready;
logic                b_ops_ready;
logic                b_reads_a;
logic                issue_a;
logic                issue_b;
logic                split;

function automatic core_pkg::lane_t make_lane(input logic vld, input core_pkg::instr_t ins,
                                              input core_pkg::word_t d1,
                                              input core_pkg::word_t d2);
    core_pkg::lane_t l;
    l.valid = vld;
    l.op = ins.op;
    l.dest = ins.dest;
    l.operand_1 = d1;
    if (ins.op == core_pkg::op_addi) begin
        l.operand_2 = {{16{ins.imm[15]}}, ins.imm};
    end
    else begin
        l.operand_2 = d2;
    end
    return l;
endfunction

// a held-back slot b goes out alone, in lane a.
assign cand_a = pending_valid ? pending_instr : issue_pair.a;
assign cand_a_valid = pending_valid || issue_valid;
assign cand_b = issue_pair.b;
assign cand_b_valid = !pending_valid && issue_valid && issue_pair.b_valid;

assign fwd_addr[0] = cand_a.src1;
assign fwd_addr[1] = cand_a.src2;
assign fwd_addr[2] = cand_b.src1;
assign fwd_addr[3] = cand_b.src2;

assign rf_addr_0 = fwd_rf_addr[0];
assign rf_addr_1 = fwd_rf_addr[1];
assign rf_addr_2 = fwd_rf_addr[2];
assign rf_addr_3 = fwd_rf_addr[3];
assign fwd_rf_data[0] = rf_data_0;
assign fwd_rf_data[1] = rf_data_1;
assign fwd_rf_data[2] = rf_data_2;
assign fwd_rf_data[3] = rf_data_3;

for (genvar i = 0; i < 4; i++) begin : g_fwd
    forwarding_unit u_forwarding_unit (
        .addr    (fwd_addr[i]),
        .valid   (fwd_valid[i]),
        .data    (fwd_data[i]),
        .rf_addr (fwd_rf_addr[i]),
        .rf_data (fwd_rf_data[i]),
        .ex_a    (ex_a),
        .ex_b    (ex_b),
        .mem_a   (mem_a),
        .mem_b   (mem_b),
        .wb_a    (wb_a),
        .wb_b    (wb_b)
    );
end

assign a_needs_src2 = cand_a.op != core_pkg::op_addi;
assign b_needs_src2 = cand_b.op != core_pkg::op_addi;
assign a_ops_ready = fwd_valid[0] && (!a_needs_src2 || fwd_valid[1]);
assign b_ops_ready = fwd_valid[2] && (!b_needs_src2 || fwd_valid[3]);

// b may not see a's result in the same cycle.
assign b_reads_a = cand_a.dest != '0 &&
                   (cand_b.src1 == cand_a.dest ||
                    (b_needs_src2 && cand_b.src2 == cand_a.dest));

assign issue_a = cand_a_valid && a_ops_ready;
assign issue_b = issue_a && cand_b_valid && b_ops_ready && !b_reads_a;
assign split = issue_a && cand_b_valid && !issue_b;

assign issue_ready = !pending_valid && a_ops_ready;

assign lane_a = make_lane(issue_a, cand_a, fwd_data[0], fwd_data[1]);
assign lane_b = make_lane(issue_b, cand_b, fwd_data[2], fwd_data[3]);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pending_valid <= 1'b0;
    end
    else if (pending_valid) begin
        if (issue_a) begin
            pending_valid <= 1'b0;
        end
    end
    else if (split) begin
        pending_valid <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (split) begin
        pending_instr <= cand_b;
    end
end

endmodule

// ==== hw/exec_pipe.sv ====
module exec_pipe (
    input wire                     clk,
    input wire                     arst_n,

    input wire  core_pkg::lane_t   lane_a,
    input wire  core_pkg::lane_t   lane_b,

    output core_pkg::bypass_t      ex_a,
    output core_pkg::bypass_t      ex_b,
    output core_pkg::bypass_t      mem_a,
    output core_pkg::bypass_t      mem_b,
    output core_pkg::bypass_t      wb_a,
    output core_pkg::bypass_t      wb_b,

    output core_pkg::commit_t      commit_a,
    output core_pkg::commit_t      commit_b
);

core_pkg::lane_t     ex_q [2];
core_pkg::word_t     alu_res [2];
core_pkg::word_t     part_lo [2];
core_pkg::word_t     part_hi [2];

logic [1:0]          mem_valid;
logic [1:0]          mem_mul;
core_pkg::reg_addr_t mem_dest [2];
core_pkg::word_t     mem_alu [2];
core_pkg::word_t     mem_lo [2];
core_pkg::word_t     mem_hi [2];
core_pkg::word_t     mem_res [2];

logic [1:0]          wb_valid;
core_pkg::reg_addr_t wb_dest [2];
core_pkg::word_t     wb_res [2];

core_pkg::bypass_t   ex_bp [2];
core_pkg::bypass_t   mem_bp [2];
core_pkg::bypass_t   wb_bp [2];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ex_q[0] <= '0;
        ex_q[1] <= '0;
    end
    else begin
        ex_q[0] <= lane_a;
        ex_q[1] <= lane_b;
    end
end

always_comb begin
    for (int i = 0; i < 2; i++) begin
        case (ex_q[i].op)
            core_pkg::op_xor: alu_res[i] = ex_q[i].operand_1 ^ ex_q[i].operand_2;
            core_pkg::op_mul: alu_res[i] = '0;
            default:          alu_res[i] = ex_q[i].operand_1 + ex_q[i].operand_2;
        endcase
        // low and high halves of the multiplier, summed in mem.
        part_lo[i] = ex_q[i].operand_1 * ex_q[i].operand_2[15:0];
        part_hi[i] = ex_q[i].operand_1 * ex_q[i].operand_2[31:16];
        ex_bp[i].valid = ex_q[i].valid;
        ex_bp[i].forwardable = ex_q[i].op != core_pkg::op_mul;
        ex_bp[i].dest = ex_q[i].dest;
        ex_bp[i].result = alu_res[i];
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mem_valid <= '0;
    end
    else begin
        mem_valid <= {ex_q[1].valid, ex_q[0].valid};
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
        mem_mul[i] <= ex_q[i].op == core_pkg::op_mul;
        mem_dest[i] <= ex_q[i].dest;
        mem_alu[i] <= alu_res[i];
        mem_lo[i] <= part_lo[i];
        mem_hi[i] <= part_hi[i];
    end
end

always_comb begin
    for (int i = 0; i < 2; i++) begin
        mem_res[i] = mem_mul[i] ? mem_lo[i] + (mem_hi[i] << 16) : mem_alu[i];
        mem_bp[i].valid = mem_valid[i];
        mem_bp[i].forwardable = 1'b1;
        mem_bp[i].dest = mem_dest[i];
        mem_bp[i].result = mem_res[i];
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        wb_valid <= '0;
    end
    else begin
        wb_valid <= mem_valid;
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
        wb_dest[i] <= mem_dest[i];
        wb_res[i] <= mem_res[i];
    end
end

always_comb begin
    for (int i = 0; i < 2; i++) begin
        wb_bp[i].valid = wb_valid[i];
        wb_bp[i].forwardable = 1'b1;
        wb_bp[i].dest = wb_dest[i];
        wb_bp[i].result = wb_res[i];
    end
end

assign ex_a = ex_bp[0];
assign ex_b = ex_bp[1];
assign mem_a = mem_bp[0];
assign mem_b = mem_bp[1];
assign wb_a = wb_bp[0];
assign wb_b = wb_bp[1];

assign commit_a = {wb_valid[0], wb_dest[0], wb_res[0]}; // wb registers retire directly.
assign commit_b = {wb_valid[1], wb_dest[1], wb_res[1]};

endmodule

// ==== hw/dual_issue_core.sv ====
module dual_issue_core (
    input wire                         clk,
    input wire                         arst_n,

    input wire                         issue_valid,
    input wire  core_pkg::issue_pair_t issue_pair,
    output logic                       issue_ready,

    output core_pkg::commit_t          commit_a,
    output core_pkg::commit_t          commit_b
);

core_pkg::bypass_t   ex_a;
core_pkg::bypass_t   ex_b;
core_pkg::bypass_t   mem_a;
core_pkg::bypass_t   mem_b;
core_pkg::bypass_t   wb_a;
core_pkg::bypass_t   wb_b;
core_pkg::reg_addr_t rf_addr [4];
core_pkg::word_t     rf_data [4];
core_pkg::lane_t     lane_a;
core_pkg::lane_t     lane_b;

issue_stage u_issue_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_pair  (issue_pair),
    .issue_ready (issue_ready),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .mem_a       (mem_a),
    .mem_b       (mem_b),
    .wb_a        (wb_a),
    .wb_b        (wb_b),
    .rf_addr_0   (rf_addr[0]),
    .rf_addr_1   (rf_addr[1]),
    .rf_addr_2   (rf_addr[2]),
    .rf_addr_3   (rf_addr[3]),
    .rf_data_0   (rf_data[0]),
    .rf_data_1   (rf_data[1]),
    .rf_data_2   (rf_data[2]),
    .rf_data_3   (rf_data[3]),
    .lane_a      (lane_a),
    .lane_b      (lane_b)
);

exec_pipe u_exec_pipe (
    .clk      (clk),
    .arst_n   (arst_n),
    .lane_a   (lane_a),
    .lane_b   (lane_b),
    .ex_a     (ex_a),
    .ex_b     (ex_b),
    .mem_a    (mem_a),
    .mem_b    (mem_b),
    .wb_a     (wb_a),
    .wb_b     (wb_b),
    .commit_a (commit_a),
    .commit_b (commit_b)
);

reg_file u_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_0 (rf_addr[0]),
    .rd_addr_1 (rf_addr[1]),
    .rd_addr_2 (rf_addr[2]),
    .rd_addr_3 (rf_addr[3]),
    .rd_data_0 (rf_data[0]),
    .rd_data_1 (rf_data[1]),
    .rd_data_2 (rf_data[2]),
    .rd_data_3 (rf_data[3]),
    .commit_a  (commit_a),
    .commit_b  (commit_b)
);

endmodule

// ==== bench/core_asserts.sv ====
module core_asserts (
    input wire                     clk,
    input wire                     arst_n,
    input wire                     issue_ready,
    input wire  core_pkg::commit_t commit_a,
    input wire  core_pkg::commit_t commit_b
);

timeunit 1ns;
timeprecision 1ps;

// lane b never retires alone.
b_needs_a: assert property (@(posedge clk) disable iff (!arst_n)
    commit_b.valid |-> commit_a.valid)
    else $error("commit_b valid while commit_a is not");

a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
    commit_a.valid |-> !$isunknown(commit_a.result))
    else $error("commit_a result has unknown bits");

b_result_known: assert property (@(posedge clk) disable iff (!arst_n)
    commit_b.valid |-> !$isunknown(commit_b.result))
    else $error("commit_b result has unknown bits");

// empty pipe, so every operand is ready.
ready_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> issue_ready)
    else $error("issue_ready low in the first cycle after reset");

endmodule

bind dual_issue_core core_asserts u_core_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_ready (issue_ready),
    .commit_a    (commit_a),
    .commit_b    (commit_b)
);

// ==== bench/tb_dual_issue.sv ====
module tb_dual_issue;

timeunit 1ns;
timeprecision 1ps;

localparam int num_pairs = 400;
localparam int max_cycles = num_pairs * 6 + 200;

logic                  clk;
logic                  arst_n;
logic                  issue_valid;
core_pkg::issue_pair_t issue_pair;
logic                  issue_ready;
core_pkg::commit_t     commit_a;
core_pkg::commit_t     commit_b;

integer                seed;
core_pkg::word_t       model_regs [32];
core_pkg::commit_t     exp_q [$];
int                    commit_count;
int                    cycles;

dual_issue_core u_dual_issue_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_pair  (issue_pair),
    .issue_ready (issue_ready),
    .commit_a    (commit_a),
    .commit_b    (commit_b)
);

always #4 clk = ~clk;

task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_commit(input string name, input core_pkg::commit_t exp,
                            input core_pkg::commit_t act);
    if (act !== exp) begin
        $display("MISMATCH %s: expected valid=%0b dest=r%0d result=%h", name,
                 exp.valid, exp.dest, exp.result);
        $display("MISMATCH %s: actual   valid=%0b dest=r%0d result=%h", name,
                 act.valid, act.dest, act.result);
        fail_run($sformatf("commit check failed in %s", name));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("MISMATCH %s: expected %b actual %b", name, exp, act);
        fail_run($sformatf("flag check failed in %s", name));
    end
endtask

task automatic random_instr(output core_pkg::instr_t ins);
    logic [31:0] r;
    r = $random(seed);
    ins.op = r[1:0];
    ins.dest = {2'b00, r[4:2]}; // only r0 to r7 for dense hazards.
    ins.src1 = {2'b00, r[7:5]};
    ins.src2 = {2'b00, r[10:8]};
    r = $random(seed);
    ins.imm = r[15:0];
endtask

// reference model step for one instruction in program order.
task automatic model_exec(input core_pkg::instr_t ins);
    core_pkg::word_t   s1;
    core_pkg::word_t   s2;
    core_pkg::word_t   res;
    core_pkg::commit_t c;
    s1 = model_regs[ins.src1];
    s2 = model_regs[ins.src2];
    case (ins.op)
        core_pkg::op_add:  res = s1 + s2;
        core_pkg::op_xor:  res = s1 ^ s2;
        core_pkg::op_addi: res = s1 + {{16{ins.imm[15]}}, ins.imm};
        default:           res = s1 * s2;
    endcase
    c.valid = 1'b1;
    c.dest = ins.dest;
    c.result = res;
    exp_q.push_back(c);
    if (ins.dest != 5'd0) begin
        model_regs[ins.dest] = res; // r0 stays zero.
    end
endtask

task automatic take_commit(input string lane, input core_pkg::commit_t act);
    core_pkg::commit_t exp;
    if (exp_q.size() == 0) begin
        fail_run($sformatf("lane %s committed r%0d with no instruction outstanding",
                           lane, act.dest));
    end
    else begin
        exp = exp_q.pop_front();
        commit_count++;
        check_commit($sformatf("random_pairs commit %0d lane %s", commit_count, lane),
                     exp, act);
    end
endtask

// lane a first keeps program order.
always @(negedge clk) begin
    if (arst_n) begin
        if (commit_a.valid) take_commit("a", commit_a);
        if (commit_b.valid) take_commit("b", commit_b);
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
        fail_run($sformatf("timeout after %0d cycles with %0d commits still outstanding",
                           cycles, exp_q.size()));
    end
end

initial begin
    core_pkg::instr_t ins_a;
    core_pkg::instr_t ins_b;
    logic [31:0]      r;
    seed = 32'h4935e05d;
    clk = 1'b0;
    arst_n = 1'b0;
    issue_valid = 1'b0;
    issue_pair = '0;
    commit_count = 0;
    cycles = 0;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("reset_idle issue_ready", 1'b1, issue_ready);
    check_flag("reset_idle commit_a valid", 1'b0, commit_a.valid);
    check_flag("reset_idle commit_b valid", 1'b0, commit_b.valid);
    @(posedge clk);
    for (int n = 0; n < num_pairs; n++) begin
        random_instr(ins_a);
        random_instr(ins_b);
        r = $random(seed);
        #1;
        issue_pair.a = ins_a;
        issue_pair.b = ins_b;
        issue_pair.b_valid = r[2:0] != 3'd0; // mostly a full pair.
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk); // pair taken here.
        model_exec(issue_pair.a);
        if (issue_pair.b_valid) model_exec(issue_pair.b);
    end
    #1;
    issue_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk); // stray commits would land here.
    $display("TEST PASSED");
    $finish;
end

endmodule

// ==== tb.f ====
hw/core_pkg.sv
hw/forwarding_unit.sv
hw/reg_file.sv
hw/issue_stage.sv
hw/exec_pipe.sv
hw/dual_issue_core.sv
bench/core_asserts.sv
bench/tb_dual_issue.sv

// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/forwarding_unit.sv
      - hw/reg_file.sv
      - hw/issue_stage.sv
      - hw/exec_pipe.sv
      - hw/dual_issue_core.sv
  - target: test
    files:
      - bench/core_asserts.sv
      - bench/tb_dual_issue.sv
